/* src/soc_pkg.sv */
package soc_pkg;

    // bus widths
    localparam int data_w = 32;
    localparam int mask_w = data_w / 8;
    localparam int addr_w = 32;

    typedef logic [data_w-1:0] word_t;
    typedef logic [mask_w-1:0] mask_t;
    typedef logic [addr_w-1:0] addr_t;

    // address map
    localparam addr_t ram_base   = 32'h0000_0000;
    localparam addr_t ram_span   = 32'h0001_0000;
    localparam addr_t clint_base = 32'h0200_0000;
    localparam addr_t clint_span = 32'h0001_0000;

    // clint register offsets within its region
    localparam addr_t clint_msip_off        = 32'h0000_0000;
    localparam addr_t clint_mtimecmp_lo_off = 32'h0000_4000;
    localparam addr_t clint_mtimecmp_hi_off = 32'h0000_4004;
    localparam addr_t clint_mtime_lo_off    = 32'h0000_BFF8;
    localparam addr_t clint_mtime_hi_off    = 32'h0000_BFFC;

    // replace the selected byte lanes of old_word with new_word
    function automatic word_t byte_merge(
        input word_t old_word,
        input word_t new_word,
        input mask_t mask
    );
        word_t result;
        result = old_word;
        for (int i = 0; i < mask_w; i++) begin
            if (mask[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

endpackage

/* src/reset_sync.sv */
`timescale 1ns/1ps

module reset_sync (
    input  logic clk,
    input  logic ext_reset,
    output logic rst_n
);

    logic [3:0] reset_cnt;

    // counts up after release and parks at all ones
    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            reset_cnt <= 4'b0000;
        end else begin
            reset_cnt <= reset_cnt + {3'b000, ~rst_n};
        end
    end

    // only the final 1110 -> 1111 step can raise this, so no glitch
    assign rst_n = &reset_cnt;

endmodule

/* src/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder
    import soc_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    // data port from the top
    input  logic  data_req,
    input  logic  data_wen,
    input  addr_t data_addr,
    input  word_t data_wdata,
    input  mask_t data_mask,
    output logic  data_ack,
    output word_t data_rdata,
    // ram path through the arbiter
    output logic  ram_req,
    output logic  ram_wen,
    output addr_t ram_addr,
    output word_t ram_wdata,
    output mask_t ram_mask,
    input  logic  ram_ack,
    input  word_t ram_rdata,
    // clint registers
    output logic  clint_wen,
    output addr_t clint_addr,
    output word_t clint_wdata,
    output mask_t clint_mask,
    input  word_t clint_rdata
);

    addr_t ram_off;
    addr_t clint_off;
    logic  ram_hit;
    logic  clint_hit;
    logic  local_ack_q;
    word_t local_rdata_q;
    logic  ram_wr_q;

    // region offsets, a hit is an offset inside the span
    assign ram_off   = data_addr - ram_base;
    assign clint_off = data_addr - clint_base;
    assign ram_hit   = ram_off < ram_span;
    assign clint_hit = clint_off < clint_span;

    assign ram_req   = data_req & ram_hit;
    assign ram_wen   = data_wen;
    assign ram_addr  = ram_off;
    assign ram_wdata = data_wdata;
    assign ram_mask  = data_mask;

    assign clint_wen   = data_req & data_wen & clint_hit;
    assign clint_addr  = clint_off;
    assign clint_wdata = data_wdata;
    assign clint_mask  = data_mask;

    // clint and unmapped accesses answer after one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            local_ack_q <= 1'b0;
        end else begin
            local_ack_q <= data_req & ~ram_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (data_req) begin
            local_rdata_q <= (clint_hit && !data_wen) ? clint_rdata : '0;
            ram_wr_q      <= data_wen;
        end
    end

    assign data_ack = local_ack_q | ram_ack;

    // writes to ram return zero, the ram output keeps stale data then
    always_comb begin
        if (local_ack_q) begin
            data_rdata = local_rdata_q;
        end else if (ram_ack && !ram_wr_q) begin
            data_rdata = ram_rdata;
        end else begin
            data_rdata = '0;
        end
    end

endmodule

/* src/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter
    import soc_pkg::*;
#(
    parameter int ram_words = 1024
) (
    input  logic                         clk,
    input  logic                         rst_n,
    // fetch requester, read only
    input  logic                         fetch_req,
    input  addr_t                        fetch_addr,
    output logic                         fetch_ack,
    output word_t                        fetch_rdata,
    // data requester from the decoder
    input  logic                         ram_req,
    input  logic                         ram_wen,
    input  addr_t                        ram_addr,
    input  word_t                        ram_wdata,
    input  mask_t                        ram_mask,
    output logic                         ram_ack,
    output word_t                        ram_rdata,
    // memory side
    output logic                         mem_en,
    output logic                         mem_we,
    output logic [$clog2(ram_words)-1:0] mem_index,
    output word_t                        mem_wdata,
    output mask_t                        mem_mask,
    input  word_t                        mem_rdata
);

    localparam int idx_w = $clog2(ram_words);

    typedef logic [idx_w-1:0] index_t;

    logic   fetch_pend;
    index_t fetch_idx_q;
    index_t fetch_idx;
    index_t data_idx;
    logic   fetch_live;
    logic   grant_data;
    logic   grant_fetch;
    logic   data_out_q;
    logic   fetch_out_q;

    // upper address bits dropped, the ram wraps
    assign data_idx  = ram_addr[idx_w+1:2];
    assign fetch_idx = fetch_req ? fetch_addr[idx_w+1:2] : fetch_idx_q;

    // fetch is live on its strobe or while waiting in its slot
    assign fetch_live = fetch_req | fetch_pend;

    // data has top priority and is always granted on its strobe,
    // so its slot is the strobe itself and never holds a request
    assign grant_data  = ram_req;
    assign grant_fetch = fetch_live & ~grant_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pend  <= 1'b0;
            data_out_q  <= 1'b0;
            fetch_out_q <= 1'b0;
        end else begin
            fetch_pend  <= fetch_live & ~grant_fetch;
            data_out_q  <= grant_data;
            fetch_out_q <= grant_fetch;
        end
    end

    // address held for a fetch that lost arbitration
    always_ff @(posedge clk) begin
        if (fetch_req) begin
            fetch_idx_q <= fetch_addr[idx_w+1:2];
        end
    end

    assign mem_en    = grant_data | grant_fetch;
    assign mem_we    = grant_data & ram_wen;
    assign mem_index = grant_data ? data_idx : fetch_idx;
    assign mem_wdata = ram_wdata;
    assign mem_mask  = ram_mask;

    // reply goes back to whoever held the grant last cycle
    assign ram_ack     = data_out_q;
    assign ram_rdata   = mem_rdata;
    assign fetch_ack   = fetch_out_q;
    assign fetch_rdata = mem_rdata;

endmodule

/* src/shared_ram.sv */
`timescale 1ns/1ps

module shared_ram
    import soc_pkg::*;
#(
    parameter int ram_words = 1024
) (
    input  logic                         clk,
    input  logic                         mem_en,
    input  logic                         mem_we,
    input  logic [$clog2(ram_words)-1:0] mem_index,
    input  word_t                        mem_wdata,
    input  mask_t                        mem_mask,
    output word_t                        mem_rdata
);

    word_t mem [ram_words];

    // lane-masked write
    always_ff @(posedge clk) begin
        if (mem_en && mem_we) begin
            for (int i = 0; i < mask_w; i++) begin
                if (mem_mask[i]) begin
                    mem[mem_index][i*8 +: 8] <= mem_wdata[i*8 +: 8];
                end
            end
        end
    end

    // registered read, held across writes
    always_ff @(posedge clk) begin
        if (mem_en && !mem_we) begin
            mem_rdata <= mem[mem_index];
        end
    end

endmodule

/* src/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer
    import soc_pkg::*;
#(
    parameter int tick_div = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clint_wen,
    input  addr_t clint_addr,
    input  word_t clint_wdata,
    input  mask_t clint_mask,
    output word_t clint_rdata,
    output logic  soft_irq,
    output logic  timer_irq
);

    localparam int div_w = $clog2(tick_div + 1);
    localparam logic [div_w-1:0] div_last = div_w'(tick_div - 1);

    logic             msip;
    logic [63:0]      mtime;
    logic [63:0]      mtimecmp;
    logic [63:0]      mtime_next;
    logic [63:0]      mtimecmp_next;
    logic [div_w-1:0] div_cnt;
    logic             tick;

    assign tick = div_cnt == div_last;

    // a register write wins over the tick for the half it touches
    always_comb begin
        mtime_next    = tick ? mtime + 64'd1 : mtime;
        mtimecmp_next = mtimecmp;
        if (clint_wen) begin
            case (clint_addr)
                clint_mtime_lo_off:
                    mtime_next[31:0] = byte_merge(mtime[31:0], clint_wdata, clint_mask);
                clint_mtime_hi_off:
                    mtime_next[63:32] = byte_merge(mtime[63:32], clint_wdata, clint_mask);
                clint_mtimecmp_lo_off:
                    mtimecmp_next[31:0] = byte_merge(mtimecmp[31:0], clint_wdata, clint_mask);
                clint_mtimecmp_hi_off:
                    mtimecmp_next[63:32] = byte_merge(mtimecmp[63:32], clint_wdata, clint_mask);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt   <= '0;
            msip      <= 1'b0;
            mtime     <= '0;
            mtimecmp  <= '1;
            timer_irq <= 1'b0;
        end else begin
            div_cnt  <= tick ? '0 : div_cnt + 1'b1;
            mtime    <= mtime_next;
            mtimecmp <= mtimecmp_next;
            if (clint_wen && clint_addr == clint_msip_off && clint_mask[0]) begin
                msip <= clint_wdata[0];
            end
            // unsigned 64-bit compare
            timer_irq <= mtime >= mtimecmp;
        end
    end

    assign soft_irq = msip;

    always_comb begin
        case (clint_addr)
            clint_msip_off:        clint_rdata = {31'b0, msip};
            clint_mtimecmp_lo_off: clint_rdata = mtimecmp[31:0];
            clint_mtimecmp_hi_off: clint_rdata = mtimecmp[63:32];
            clint_mtime_lo_off:    clint_rdata = mtime[31:0];
            clint_mtime_hi_off:    clint_rdata = mtime[63:32];
            default:               clint_rdata = '0;
        endcase
    end

endmodule

/* src/soc_top.sv */
`timescale 1ns/1ps

module soc_top
    import soc_pkg::*;
#(
    parameter int ram_words = 1024,
    parameter int tick_div  = 4
) (
    input  logic  clk,
    input  logic  ext_reset,
    // instruction fetch port
    input  logic  fetch_req,
    input  addr_t fetch_addr,
    output logic  fetch_ack,
    output word_t fetch_rdata,
    // data port
    input  logic  data_req,
    input  logic  data_wen,
    input  addr_t data_addr,
    input  word_t data_wdata,
    input  mask_t data_mask,
    output logic  data_ack,
    output word_t data_rdata,
    // interrupts
    output logic  soft_irq,
    output logic  timer_irq
);

    localparam int idx_w = $clog2(ram_words);

    logic             rst_n;
    logic             ram_req;
    logic             ram_wen;
    addr_t            ram_addr;
    word_t            ram_wdata;
    mask_t            ram_mask;
    logic             ram_ack;
    word_t            ram_rdata;
    logic             clint_wen;
    addr_t            clint_addr;
    word_t            clint_wdata;
    mask_t            clint_mask;
    word_t            clint_rdata;
    logic             mem_en;
    logic             mem_we;
    logic [idx_w-1:0] mem_index;
    word_t            mem_wdata;
    mask_t            mem_mask;
    word_t            mem_rdata;

    reset_sync reset_sync_i (
        .clk       (clk),
        .ext_reset (ext_reset),
        .rst_n     (rst_n)
    );

    bus_decoder bus_decoder_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_req    (data_req),
        .data_wen    (data_wen),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_mask   (data_mask),
        .data_ack    (data_ack),
        .data_rdata  (data_rdata),
        .ram_req     (ram_req),
        .ram_wen     (ram_wen),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_mask    (ram_mask),
        .ram_ack     (ram_ack),
        .ram_rdata   (ram_rdata),
        .clint_wen   (clint_wen),
        .clint_addr  (clint_addr),
        .clint_wdata (clint_wdata),
        .clint_mask  (clint_mask),
        .clint_rdata (clint_rdata)
    );

    mem_arbiter #(
        .ram_words (ram_words)
    ) mem_arbiter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ack   (fetch_ack),
        .fetch_rdata (fetch_rdata),
        .ram_req     (ram_req),
        .ram_wen     (ram_wen),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_mask    (ram_mask),
        .ram_ack     (ram_ack),
        .ram_rdata   (ram_rdata),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_index   (mem_index),
        .mem_wdata   (mem_wdata),
        .mem_mask    (mem_mask),
        .mem_rdata   (mem_rdata)
    );

    shared_ram #(
        .ram_words (ram_words)
    ) shared_ram_i (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_index (mem_index),
        .mem_wdata (mem_wdata),
        .mem_mask  (mem_mask),
        .mem_rdata (mem_rdata)
    );

    clint_timer #(
        .tick_div (tick_div)
    ) clint_timer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .clint_wen   (clint_wen),
        .clint_addr  (clint_addr),
        .clint_wdata (clint_wdata),
        .clint_mask  (clint_mask),
        .clint_rdata (clint_rdata),
        .soft_irq    (soft_irq),
        .timer_irq   (timer_irq)
    );

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top
    import soc_pkg::*;
;

    localparam int ram_words     = 1024;
    localparam int tick_div      = 4;
    localparam int ram_slots     = 16;
    localparam int ram_merges    = 24;
    localparam int shared_rounds = 8;
    localparam int timer_gap     = 50;
    // worst case per access is setup, two cycles of latency and some slack
    localparam int access_len    = 5;
    localparam int reset_len     = 3 + 15 + 4;
    localparam int ram_len       = (2 * ram_slots + ram_merges) * access_len;
    localparam int shared_len    = shared_rounds * access_len;
    localparam int decode_len    = 6 * access_len;
    localparam int timer_len     = 6 * access_len + timer_gap + 40 + 2;
    localparam int max_cycles    =
        2 * (reset_len + ram_len + shared_len + decode_len + timer_len);

    logic  clk;
    logic  ext_reset;
    logic  fetch_req;
    addr_t fetch_addr;
    logic  fetch_ack;
    word_t fetch_rdata;
    logic  data_req;
    logic  data_wen;
    addr_t data_addr;
    word_t data_wdata;
    mask_t data_mask;
    logic  data_ack;
    word_t data_rdata;
    logic  soft_irq;
    logic  timer_irq;

    logic        rst_window;
    logic [31:0] lfsr_state;
    word_t       ref_mem [ram_words];
    logic [9:0]  used_idx [ram_slots];
    logic [32:0] data_exp_q [$];
    logic [32:0] fetch_exp_q [$];
    logic [32:0] data_exp;
    logic [32:0] fetch_exp;
    word_t       last_rdata;
    int          last_lat;
    int          last_cyc;
    int          cyc = 0;
    int          errors;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    string       cur_test;

    soc_top #(
        .ram_words (ram_words),
        .tick_div  (tick_div)
    ) dut_i (
        .clk         (clk),
        .ext_reset   (ext_reset),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ack   (fetch_ack),
        .fetch_rdata (fetch_rdata),
        .data_req    (data_req),
        .data_wen    (data_wen),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_mask   (data_mask),
        .data_ack    (data_ack),
        .data_rdata  (data_rdata),
        .soft_irq    (soft_irq),
        .timer_irq   (timer_irq)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc == max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic value_error(input string what, input word_t expv, input word_t actv);
        errors++;
        test_errs++;
        $display("error %s %s: expected %h actual %h", cur_test, what, expv, actv);
    endtask

    task automatic fail_note(input string msg);
        errors++;
        test_errs++;
        $display("%s: %s", cur_test, msg);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // expand each lane bit to a byte wide keep mask
    function automatic word_t merge_lanes(input word_t old_w, input word_t new_w,
                                          input mask_t lanes);
        word_t keep;
        keep = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        return (old_w & ~keep) | (new_w & keep);
    endfunction

    // random bits above the ram depth but inside the ram region
    function automatic addr_t ram_byte_addr(input logic [9:0] idx);
        return {16'h0000, 4'(take_bits(4)), idx, 2'b00};
    endfunction

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("test %-8s ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %-8s %0d errors", cur_test, test_errs);
        end
    endtask

    task automatic data_access(input logic wen, input addr_t addr, input word_t wdata,
                               input mask_t mask, input logic check, input word_t expv);
        data_exp_q.push_back({check, expv});
        @(posedge clk);
        last_cyc   = cyc;
        data_req   <= 1'b1;
        data_wen   <= wen;
        data_addr  <= addr;
        data_wdata <= wdata;
        data_mask  <= mask;
        @(posedge clk);
        data_req <= 1'b0;
        last_lat = 1;
        @(negedge clk);
        while (!data_ack) begin
            @(negedge clk);
            last_lat++;
        end
        last_rdata = data_rdata;
    endtask

    task automatic ram_write(input logic [9:0] idx, input word_t wdata, input mask_t mask);
        ref_mem[idx] = merge_lanes(ref_mem[idx], wdata, mask);
        data_access(1'b1, ram_byte_addr(idx), wdata, mask, 1'b1, '0);
    endtask

    // data and fetch strobes in the same cycle
    task automatic dual_read(input logic [9:0] didx, input addr_t faddr);
        int t;
        int data_at;
        int fetch_at;
        data_exp_q.push_back({1'b1, ref_mem[didx]});
        fetch_exp_q.push_back({1'b1, ref_mem[faddr[11:2]]});
        @(posedge clk);
        data_req   <= 1'b1;
        data_wen   <= 1'b0;
        data_addr  <= ram_byte_addr(didx);
        fetch_req  <= 1'b1;
        fetch_addr <= faddr;
        @(posedge clk);
        data_req  <= 1'b0;
        fetch_req <= 1'b0;
        t = 1;
        data_at = 0;
        fetch_at = 0;
        while (data_at == 0 || fetch_at == 0) begin
            @(negedge clk);
            if (data_ack) begin
                data_at = t;
            end
            if (fetch_ack) begin
                fetch_at = t;
            end
            t++;
        end
        assert (data_at == 1) else value_error("data latency", 1, word_t'(data_at));
        assert (fetch_at == 2) else value_error("fetch latency", 2, word_t'(fetch_at));
    endtask

    // read data checked against the reference in ack order
    always @(negedge clk) begin
        if (data_ack) begin
            if (data_exp_q.size() == 0) begin
                fail_note("data ack with no request outstanding");
            end else begin
                data_exp = data_exp_q.pop_front();
                if (data_exp[32]) begin
                    assert (data_rdata == data_exp[31:0])
                        else value_error("data read", data_exp[31:0], data_rdata);
                end
            end
        end
    end

    always @(negedge clk) begin
        if (fetch_ack) begin
            if (fetch_exp_q.size() == 0) begin
                fail_note("fetch ack with no request outstanding");
            end else begin
                fetch_exp = fetch_exp_q.pop_front();
                assert (fetch_rdata == fetch_exp[31:0])
                    else value_error("fetch read", fetch_exp[31:0], fetch_rdata);
            end
        end
    end

    assert property (@(posedge clk)
        rst_window |-> !(fetch_ack || data_ack || soft_irq || timer_irq))
        else fail_note("an output was high before reset release");

    assert property (@(posedge clk) data_ack |-> ($past(data_req) || $past(data_req, 2)))
        else fail_note("data ack not 1 to 2 cycles after its strobe");

    assert property (@(posedge clk) fetch_ack |-> ($past(fetch_req) || $past(fetch_req, 2)))
        else fail_note("fetch ack not 1 to 2 cycles after its strobe");

    assert property (@(posedge clk) data_ack |=> !data_ack)
        else fail_note("data ack lasted more than one cycle");

    assert property (@(posedge clk) fetch_ack |=> !fetch_ack)
        else fail_note("fetch ack lasted more than one cycle");

    // msip only moves on a data port write
    assert property (@(posedge clk)
        (soft_irq != $past(soft_irq)) |-> $past(data_req && data_wen))
        else fail_note("soft_irq changed without a write");

    task automatic reset_release_test();
        start_test("reset");
        repeat (3) @(posedge clk);
        ext_reset <= 1'b1;
        repeat (5) @(posedge clk);
        // these strobes land while the internal reset is still low
        data_req  <= 1'b1;
        fetch_req <= 1'b1;
        @(posedge clk);
        data_req  <= 1'b0;
        fetch_req <= 1'b0;
        repeat (9) @(posedge clk);
        rst_window <= 1'b0;
        repeat (3) @(posedge clk);
        end_test();
    endtask

    task automatic masked_ram_test();
        logic [3:0] k;
        start_test("ram");
        for (int i = 0; i < ram_slots; i++) begin
            used_idx[i] = 10'(take_bits(10));
            ram_write(used_idx[i], take_bits(32), 4'b1111);
        end
        for (int i = 0; i < ram_merges; i++) begin
            k = 4'(take_bits(4));
            ram_write(used_idx[k], take_bits(32), mask_t'(take_bits(4)));
        end
        for (int i = 0; i < ram_slots; i++) begin
            data_access(1'b0, ram_byte_addr(used_idx[i]), '0, '1, 1'b1, ref_mem[used_idx[i]]);
        end
        end_test();
    endtask

    task automatic shared_memory_test();
        logic [3:0] k;
        addr_t      faddr;
        start_test("shared");
        for (int i = 0; i < shared_rounds; i++) begin
            k = 4'(take_bits(4));
            // junk upper fetch address bits wrap onto the ram
            faddr = {20'(take_bits(20)), used_idx[k], 2'b00};
            k = 4'(take_bits(4));
            dual_read(used_idx[k], faddr);
        end
        end_test();
    endtask

    task automatic decode_test();
        start_test("decode");
        data_access(1'b0, 32'h1000_0000, '0, '1, 1'b1, '0);
        assert (last_lat == 1) else value_error("unmapped latency", 1, word_t'(last_lat));
        data_access(1'b1, clint_base + clint_msip_off, 32'h1, 4'b0001, 1'b1, '0);
        assert (soft_irq == 1'b1) else value_error("soft_irq set", 1, word_t'(soft_irq));
        data_access(1'b0, clint_base + clint_msip_off, '0, '1, 1'b1, 32'h1);
        data_access(1'b1, clint_base + clint_msip_off, 32'h0, 4'b0001, 1'b1, '0);
        assert (soft_irq == 1'b0) else value_error("soft_irq clear", 0, word_t'(soft_irq));
        data_access(1'b0, clint_base + clint_msip_off, '0, '1, 1'b1, 32'h0);
        end_test();
    endtask

    task automatic timer_test();
        int    t0;
        int    n;
        int    w;
        word_t m0;
        word_t lo;
        word_t diff;
        start_test("timer");
        data_access(1'b0, clint_base + clint_mtime_lo_off, '0, '1, 1'b0, '0);
        t0 = last_cyc;
        m0 = last_rdata;
        repeat (timer_gap) @(posedge clk);
        data_access(1'b0, clint_base + clint_mtime_lo_off, '0, '1, 1'b0, '0);
        n    = last_cyc - t0;
        lo   = word_t'(n / tick_div);
        diff = last_rdata - m0;
        assert (diff >= lo && diff <= lo + 1) else value_error("mtime step", lo, diff);

        // compare point a few ticks ahead with the low half written first
        data_access(1'b0, clint_base + clint_mtime_lo_off, '0, '1, 1'b0, '0);
        m0 = last_rdata + 32'd8;
        data_access(1'b1, clint_base + clint_mtimecmp_lo_off, m0, '1, 1'b1, '0);
        data_access(1'b1, clint_base + clint_mtimecmp_hi_off, 32'h0, '1, 1'b1, '0);
        w = 0;
        while (!timer_irq && w < 40) begin
            @(negedge clk);
            w++;
        end
        assert (timer_irq) else fail_note("timer_irq did not rise within 40 cycles");

        data_access(1'b1, clint_base + clint_mtimecmp_hi_off, 32'hFFFF_FFFF, '1, 1'b1, '0);
        w = 0;
        while (timer_irq && w < 2) begin
            @(negedge clk);
            w++;
        end
        assert (!timer_irq) else fail_note("timer_irq did not drop within 2 cycles");
        end_test();
    endtask

    initial begin
        clk          = 1'b0;
        ext_reset    <= 1'b0;
        fetch_req    <= 1'b0;
        fetch_addr   <= '0;
        data_req     <= 1'b0;
        data_wen     <= 1'b0;
        data_addr    <= '0;
        data_wdata   <= '0;
        data_mask    <= '0;
        rst_window   <= 1'b1;
        lfsr_state   = 32'h6491;
        errors       = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "init";

        reset_release_test();
        masked_ram_test();
        shared_memory_test();
        decode_test();
        timer_test();

        repeat (3) @(posedge clk);
        if (data_exp_q.size() != 0 || fetch_exp_q.size() != 0) begin
            fail_note("requests left without an ack");
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
src/soc_pkg.sv
src/reset_sync.sv
src/bus_decoder.sv
src/mem_arbiter.sv
src/shared_ram.sv
src/clint_timer.sv
src/soc_top.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_top -f tb.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
else
    echo "run.sh: simulation did not pass"
    exit 1
fi
